/* common/sadPkg.sv */
`default_nettype none

package sadPkg;

    // Frame and block geometry
    localparam int PixelWidth  = 8;
    localparam int FrameDim    = 64;
    localparam int CoordWidth  = 6;
    localparam int BlockDim    = 4;
    localparam int BlockPixels = BlockDim * BlockDim;

    // Sixteen 8-bit differences peak at 4080, so 12 bits hold any SAD
    localparam int SadWidth = 12;

    typedef logic [PixelWidth-1:0] pixelT;
    typedef logic [CoordWidth-1:0] coordT;
    typedef logic [SadWidth-1:0]   sadT;

    // Minimum starts out above every reachable SAD
    localparam sadT SadMax = '1;

    // Row sits in the upper half of the flat frame address
    typedef struct packed {
        coordT row;
        coordT col;
    } frameAddrT;

    // Row-major, index 0 is the block origin
    typedef logic [BlockPixels-1:0][PixelWidth-1:0] pixelBlockT;

    // Block read stage: frame pixels next to the template copy
    typedef struct packed {
        logic       valid;
        frameAddrT  origin;
        pixelBlockT frame;
        pixelBlockT tmpl;
    } pairStageT;

    // Absolute difference stage
    typedef struct packed {
        logic       valid;
        frameAddrT  origin;
        pixelBlockT diff;
    } diffStageT;

    // Sum stage, one SAD per candidate
    typedef struct packed {
        logic      valid;
        frameAddrT origin;
        sadT       sad;
    } sumStageT;

endpackage

`default_nettype wire

/* common/hostPkg.sv */
`default_nettype none

package hostPkg;

    // Host command opcodes, one strobe per cycle
    typedef enum logic [1:0] {
        opIdle,
        opLoadFrame,
        opLoadTemplate,
        opSearch
    } hostOpT;

    // opLoadFrame writes data at addr
    // opLoadTemplate uses the low 4 bits of addr as the row-major index
    // opSearch takes addr as the candidate origin
    typedef struct packed {
        hostOpT            op;
        sadPkg::frameAddrT addr;
        sadPkg::pixelT     data;
    } hostCmdT;

    // Best candidate seen since reset
    typedef struct packed {
        sadPkg::sadT   minSad;
        sadPkg::coordT row;
        sadPkg::coordT col;
    } sadResultT;

endpackage

`default_nettype wire

/* sad/pixelStore.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelStore (
    input  logic              Clk,
    input  logic              rst,
    input  hostPkg::hostCmdT  hostCmd,
    output sadPkg::pairStageT pair
);

    import sadPkg::*;
    import hostPkg::*;

    // 64x64 frame, addressed as {row, col}
    pixelT frameMem [FrameDim*FrameDim];

    pixelBlockT templateReg;
    pixelBlockT frameBlock;

    logic isSearch;
    logic isFrameWr;
    logic isTemplateWr;

    assign isSearch     = (hostCmd.op == opSearch);
    assign isFrameWr    = (hostCmd.op == opLoadFrame);
    assign isTemplateWr = (hostCmd.op == opLoadTemplate);

    // Host writes into frame memory
    always_ff @(posedge Clk) begin
        if (isFrameWr) begin
            frameMem[{hostCmd.addr.row, hostCmd.addr.col}] <= hostCmd.data;
        end
    end

    // Template pixel index comes from the low address bits
    always_ff @(posedge Clk) begin
        if (isTemplateWr) begin
            templateReg[hostCmd.addr[3:0]] <= hostCmd.data;
        end
    end

    // All 16 lanes read the frame in parallel at the candidate origin
    always_comb begin : blockRead
        coordT rdRow;
        coordT rdCol;
        for (int r = 0; r < BlockDim; r++) begin
            for (int c = 0; c < BlockDim; c++) begin
                rdRow = hostCmd.addr.row + coordT'(r);
                rdCol = hostCmd.addr.col + coordT'(c);
                frameBlock[r*BlockDim + c] = frameMem[{rdRow, rdCol}];
            end
        end
    end

    // Stage register, only valid needs a reset
    always_ff @(posedge Clk) begin
        if (rst) begin
            pair.valid <= 1'b0;
        end else begin
            pair.valid <= isSearch;
        end

        // Payload only matters when a search is launched
        if (isSearch) begin
            pair.origin <= hostCmd.addr;
            pair.frame  <= frameBlock;
            pair.tmpl   <= templateReg;
        end
    end

endmodule

`default_nettype wire

/* sad/absDiff.sv */
`timescale 1ns/1ps
`default_nettype none

module absDiff (
    input  logic              Clk,
    input  logic              rst,
    input  sadPkg::pairStageT pair,
    output sadPkg::diffStageT diff
);

    import sadPkg::*;

    pixelBlockT absBlock;

    // Unsigned |frame - template| per lane, always fits in a pixel
    always_comb begin
        for (int i = 0; i < BlockPixels; i++) begin
            if (pair.frame[i] > pair.tmpl[i]) begin
                absBlock[i] = pair.frame[i] - pair.tmpl[i];
            end else begin
                absBlock[i] = pair.tmpl[i] - pair.frame[i];
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            diff.valid <= 1'b0;
        end else begin
            diff.valid <= pair.valid;
        end

        // Carried along with the lanes
        diff.origin <= pair.origin;
        diff.diff   <= absBlock;
    end

endmodule

`default_nettype wire

/* sad/sumTree.sv */
`timescale 1ns/1ps
`default_nettype none

module sumTree (
    input  logic              Clk,
    input  logic              rst,
    input  sadPkg::diffStageT diff,
    output sadPkg::sumStageT  sum
);

    import sadPkg::*;

    // Each level grows by one bit, four levels reach SadWidth
    logic [PixelWidth:0]   lvl1 [8];
    logic [PixelWidth+1:0] lvl2 [4];
    logic [PixelWidth+2:0] lvl3 [2];
    sadT                   total;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            lvl1[i] = {1'b0, diff.diff[2*i]} + {1'b0, diff.diff[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            lvl2[i] = {1'b0, lvl1[2*i]} + {1'b0, lvl1[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            lvl3[i] = {1'b0, lvl2[2*i]} + {1'b0, lvl2[2*i+1]};
        end
        total = {1'b0, lvl3[0]} + {1'b0, lvl3[1]};
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            sum.valid <= 1'b0;
        end else begin
            sum.valid <= diff.valid;
        end

        sum.origin <= diff.origin;
        sum.sad    <= total;
    end

endmodule

`default_nettype wire

/* sad/minTracker.sv */
`timescale 1ns/1ps
`default_nettype none

module minTracker (
    input  logic               Clk,
    input  logic               rst,
    input  sadPkg::sumStageT   sum,
    output hostPkg::sadResultT result,
    output logic               resultValid
);

    import sadPkg::*;

    logic better;

    // Strictly less, so on a tie the earlier candidate is kept
    assign better = sum.valid && (sum.sad < result.minSad);

    always_ff @(posedge Clk) begin
        if (rst) begin
            result.minSad <= SadMax;
            result.row    <= '0;
            result.col    <= '0;
        end else if (better) begin
            result.minSad <= sum.sad;
            result.row    <= sum.origin.row;
            result.col    <= sum.origin.col;
        end
    end

    // One pulse per finished candidate, minimum changed or not
    always_ff @(posedge Clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= sum.valid;
        end
    end

endmodule

`default_nettype wire

/* src/sadTop.sv */
`timescale 1ns/1ps
`default_nettype none

module sadTop (
    input  logic               Clk,
    input  logic               rst,
    input  hostPkg::hostCmdT   hostCmd,
    output hostPkg::sadResultT result,
    output logic               resultValid
);

    import sadPkg::*;

    // Stage registers between the four pipeline blocks
    pairStageT pair;
    diffStageT diff;
    sumStageT  sum;

    // Block read from frame memory plus template snapshot
    pixelStore u_pixelStore (
        .Clk     (Clk),
        .rst     (rst),
        .hostCmd (hostCmd),
        .pair    (pair)
    );

    absDiff u_absDiff (
        .Clk  (Clk),
        .rst  (rst),
        .pair (pair),
        .diff (diff)
    );

    sumTree u_sumTree (
        .Clk  (Clk),
        .rst  (rst),
        .diff (diff),
        .sum  (sum)
    );

    // Running minimum with best row and column
    minTracker u_minTracker (
        .Clk         (Clk),
        .rst         (rst),
        .sum         (sum),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

/* sim/sadTasks.svh */
`ifndef SAD_TASKS_SVH
`define SAD_TASKS_SVH
`default_nettype none

function automatic hostCmdT makeCmd(input hostOpT op, input int row, input int col,
                                    input int data);
    hostCmdT cmd;
    cmd.op       = op;
    cmd.addr.row = coordT'(row);
    cmd.addr.col = coordT'(col);
    cmd.data     = pixelT'(data);
    return cmd;
endfunction

task automatic checkValue(input string name, input int expected, input int actual);
    assert (expected == actual)
        else failNow($sformatf("Error at %0t: %s expected %0d got %0d",
                               $time, name, expected, actual));
endtask

// Samples the outputs on the falling edge, then drives the next command
task automatic stepCycle(input hostCmdT cmd);
    sadResultT exp;
    int        due;
    @(negedge Clk);
    cycleIndex++;
    if (resultValid) begin
        assert (expResult.size() > 0)
            else failNow("resultValid pulsed while no search was in flight");
        exp = expResult.pop_front();
        due = expCycle.pop_front();
        checkValue("resultValid cycle", due, cycleIndex);
        checkValue("result.minSad", int'(exp.minSad), int'(result.minSad));
        checkValue("result.row", int'(exp.row), int'(result.row));
        checkValue("result.col", int'(exp.col), int'(result.col));
    end
    hostCmd = cmd;
    if (cmd.op == opSearch) begin
        trackCandidate(int'(cmd.addr.row), int'(cmd.addr.col));
        exp.minSad = sadT'(modelMin);
        exp.row    = coordT'(modelRow);
        exp.col    = coordT'(modelCol);
        expResult.push_back(exp);
        // Result shows 4 edges after the search is sampled
        expCycle.push_back(cycleIndex + 4);
    end
endtask

task automatic applyReset();
    @(negedge Clk);
    cycleIndex++;
    rst     = 1'b1;
    hostCmd = makeCmd(opIdle, 0, 0, 0);
    repeat (ResetCycles) begin
        @(negedge Clk);
        cycleIndex++;
    end
    rst = 1'b0;
    expResult.delete();
    expCycle.delete();
    clearMinimum();
endtask

task automatic writeFramePixel(input int row, input int col, input int data);
    frameModel[row * FrameDim + col] = data;
    stepCycle(makeCmd(opLoadFrame, row, col, data));
endtask

task automatic writeTemplatePixel(input int idx, input int data);
    templModel[idx] = data;
    stepCycle(makeCmd(opLoadTemplate, 0, idx, data));
endtask

task automatic loadRandomFrame();
    for (int r = 0; r < FrameDim; r++) begin
        for (int c = 0; c < FrameDim; c++) begin
            writeFramePixel(r, c, $random(seed) & 32'hFF);
        end
    end
endtask

task automatic loadRandomTemplate();
    for (int i = 0; i < BlockPixels; i++) begin
        writeTemplatePixel(i, $random(seed) & 32'hFF);
    end
endtask

task automatic searchAt(input int row, input int col);
    stepCycle(makeCmd(opSearch, row, col, 0));
endtask

task automatic drainResults();
    int waited;
    waited = 0;
    while (expResult.size() > 0 && waited < DrainBudget) begin
        stepCycle(makeCmd(opIdle, 0, 0, 0));
        waited++;
    end
    assert (expResult.size() == 0)
        else failNow("search results still missing after the drain timeout");
    // Quiet cycles catch stray pulses
    repeat (3) stepCycle(makeCmd(opIdle, 0, 0, 0));
endtask

task automatic idleAfterReset();
    applyReset();
    repeat (8) stepCycle(makeCmd(opIdle, 0, 0, 0));
    checkValue("result.minSad", (1 << SadWidth) - 1, int'(result.minSad));
    checkValue("result.row", 0, int'(result.row));
    checkValue("result.col", 0, int'(result.col));
endtask

task automatic exactMatchLatency();
    int matchRow;
    int matchCol;
    matchRow = 17;
    matchCol = 42;
    applyReset();
    loadRandomFrame();
    for (int i = 0; i < BlockPixels; i++) begin
        writeTemplatePixel(i, frameModel[(matchRow + i / BlockDim) * FrameDim
                                         + matchCol + i % BlockDim]);
    end
    searchAt(0, 0);
    drainResults();
    searchAt(60, 60);
    drainResults();
    searchAt(33, 5);
    drainResults();
    searchAt(matchRow, matchCol);
    drainResults();
    checkValue("result.minSad", 0, int'(result.minSad));
    checkValue("result.row", matchRow, int'(result.row));
    checkValue("result.col", matchCol, int'(result.col));
endtask

task automatic backToBackSearch();
    applyReset();
    loadRandomFrame();
    loadRandomTemplate();
    for (int n = 0; n < 20; n++) begin
        searchAt($unsigned($random(seed)) % 61, $unsigned($random(seed)) % 61);
    end
    drainResults();
endtask

task automatic tieKeepsFirst();
    applyReset();
    loadRandomFrame();
    loadRandomTemplate();
    // Same block at a second origin
    for (int i = 0; i < BlockPixels; i++) begin
        writeFramePixel(40 + i / BlockDim, 30 + i % BlockDim,
                        frameModel[(5 + i / BlockDim) * FrameDim + 9 + i % BlockDim]);
    end
    searchAt(5, 9);
    searchAt(40, 30);
    drainResults();
    checkValue("result.minSad", blockSad(40, 30), int'(result.minSad));
    checkValue("result.row", 5, int'(result.row));
    checkValue("result.col", 9, int'(result.col));
endtask

task automatic inFlightIsolation();
    int framePix;
    int firstSad;
    applyReset();
    loadRandomFrame();
    loadRandomTemplate();
    // Lane 6 sits at row 1, col 2 of the block
    framePix = frameModel[31 * FrameDim + 14];
    writeTemplatePixel(6, framePix ^ 32'h80);
    firstSad = blockSad(30, 12);
    searchAt(30, 12);
    writeTemplatePixel(6, framePix);
    searchAt(30, 12);
    drainResults();
    checkValue("result.minSad", firstSad - 128, int'(result.minSad));
endtask

`default_nettype wire
`endif

/* sim/sadTb.sv */
`timescale 1ns/1ps
`default_nettype none

module sadTb;

    import sadPkg::*;
    import hostPkg::*;

    localparam int ResetCycles   = 5;
    localparam int FrameLoadCmds = FrameDim * FrameDim;
    localparam int DrainBudget   = 10;
    localparam int SearchCmds    = 4 + 20 + 2 + 2;

    // Four full frame loads, template writes and the block copy, searches,
    // five resets, the idle stretch of the reset test and seven full drains
    localparam int CommandCount = 4 * FrameLoadCmds + 5 * BlockPixels + 2
                                + SearchCmds + 5 * (ResetCycles + 1) + 8
                                + 7 * (DrainBudget + 3);
    localparam int CycleLimit   = CommandCount + CommandCount / 4;

    logic      Clk;
    logic      rst;
    hostCmdT   hostCmd;
    sadResultT result;
    logic      resultValid;

    int seed;
    int cycleCount;
    int cycleIndex;

    // Mirror of the frame memory and template registers
    int frameModel [FrameDim*FrameDim];
    int templModel [BlockPixels];

    // Running minimum of the model
    int modelMin;
    int modelRow;
    int modelCol;

    // Searches in flight in issue order
    sadResultT expResult [$];
    int        expCycle [$];

    sadTop u_sadTop (
        .Clk         (Clk),
        .rst         (rst),
        .hostCmd     (hostCmd),
        .result      (result),
        .resultValid (resultValid)
    );

    always #50 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            failNow($sformatf("Timeout: test sequence did not finish within %0d cycles",
                              CycleLimit));
        end
    end

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    // Sum of absolute differences over the 4x4 block at the origin
    function automatic int blockSad(input int row, input int col);
        int total;
        int a;
        int b;
        total = 0;
        for (int r = 0; r < BlockDim; r++) begin
            for (int c = 0; c < BlockDim; c++) begin
                a = frameModel[(row + r) * FrameDim + col + c];
                b = templModel[r * BlockDim + c];
                total += (a > b) ? (a - b) : (b - a);
            end
        end
        return total;
    endfunction

    // Only a strictly smaller SAD replaces the earlier candidate
    task automatic trackCandidate(input int row, input int col);
        int s;
        s = blockSad(row, col);
        if (s < modelMin) begin
            modelMin = s;
            modelRow = row;
            modelCol = col;
        end
    endtask

    task automatic clearMinimum();
        modelMin = (1 << SadWidth) - 1;
        modelRow = 0;
        modelCol = 0;
    endtask

    initial begin
        Clk        = 1'b0;
        rst        = 1'b1;
        hostCmd    = '0;
        seed       = 32'h669851e5;
        cycleCount = 0;
        cycleIndex = 0;
        clearMinimum();

        idleAfterReset();
        exactMatchLatency();
        backToBackSearch();
        tieKeepsFirst();
        inFlightIsolation();

        $display("TB PASSED");
        $finish;
    end

    `include "sadTasks.svh"

endmodule

`default_nettype wire

/* src.f */
+incdir+sim
common/sadPkg.sv
common/hostPkg.sv
sad/pixelStore.sv
sad/absDiff.sv
sad/sumTree.sv
sad/minTracker.sv
src/sadTop.sv
sim/sadTb.sv

/* Makefile */
# Verilator build and run for the SAD accelerator testbench

VERILATOR ?= verilator
TOP       ?= sadTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
